// File: draw_board.f
verilog/vga_pkg.sv
verilog/board_pkg.sv
verilog/board_locator.sv
verilog/card_tile.sv
verilog/board_mixer.sv
verilog/top_draw_board.sv
verif/top_draw_board_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the board drawing testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module top_draw_board_tb \
    -f draw_board.f --Mdir obj_dir -o top_draw_board_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/top_draw_board_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Test failed" "$LOG"; then
    echo "Simulation reported a failure, see $LOG"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi
if ! grep -q "Test passed" "$LOG"; then
    echo "Simulation ended without a result line"
    exit 1
fi
exit 0

// File: verif/top_draw_board_tb.sv
`timescale 1ns/1ps

module top_draw_board_tb
    import vga_pkg::*;
    import board_pkg::*;
();

    localparam int GRID_X0      = 64;
    localparam int GRID_Y0      = 48;
    localparam int FACE_CYCLES  = NUM_CARDS * GLYPH_DIM * GLYPH_DIM;
    localparam int RAND_CYCLES  = 4000;
    localparam int FRAME_CYCLES = 6 + 1 + 4 + 2 * TILE_SIZE;
    localparam int TEST_CYCLES  = 4 + FACE_CYCLES + RAND_CYCLES + FRAME_CYCLES + 3;
    localparam int CYCLE_LIMIT  = TEST_CYCLES + 100;

    logic        clk;
    logic        rst;
    vga_sig_t    vga_in;
    logic        mouse_left;
    logic        mouse_right;
    mouse_pos_t  xpos;
    mouse_pos_t  ypos;
    game_state_t game_state;
    vga_sig_t    vga_out;

    logic [15:0]          lfsr_state = 16'd45;
    logic [NUM_CARDS-1:0] flip_model;
    int                   your_card_model;
    logic                 your_valid_model;
    vga_sig_t             pipe [$];
    int                   settle;
    int                   cycle_count = 0;
    int                   flips_seen;
    int                   picks_seen;
    int                   board_checks;
    int                   frame_checks;

    top_draw_board #(
        .GRID_X0(GRID_X0),
        .GRID_Y0(GRID_Y0)
    ) u_top_draw_board (
        .clk,
        .rst,
        .vga_in,
        .mouse_left,
        .mouse_right,
        .xpos,
        .ypos,
        .game_state,
        .vga_out
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            report_failure($sformatf("Timeout: run still busy after %0d cycles", cycle_count));
        end
    end

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_vga(input string name, input vga_sig_t got, input vga_sig_t exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_rgb(input string name, input rgb_t got, input rgb_t exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    // Galois LFSR for x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic next_bit();
        logic lsb;
        lsb        = lfsr_state[0];
        lfsr_state = {1'b0, lfsr_state[15:1]};
        if (lsb) begin
            lfsr_state = lfsr_state ^ 16'hB400;
        end
        return lsb;
    endfunction

    function automatic int rand_bits(input int n);
        int r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            r = r * 2 + (next_bit() ? 1 : 0);
        end
        return r;
    endfunction

    // Mostly near the board and sometimes anywhere on screen.
    function automatic int biased_coord(input int origin);
        if (rand_bits(2) != 0) begin
            return origin - 8 + rand_bits(8) % 208;
        end
        return rand_bits(11);
    endfunction

    function automatic vga_sig_t board_pixel(input int x, input int y);
        vga_sig_t p;
        p.hcount = coord_t'(x);
        p.vcount = coord_t'(y);
        p.hsync  = next_bit();
        p.vsync  = next_bit();
        p.hblnk  = 1'b0;
        p.vblnk  = 1'b0;
        p.rgb    = rgb_t'(rand_bits(12));
        return p;
    endfunction

    function automatic vga_sig_t random_pixel();
        vga_sig_t p;
        p       = board_pixel(biased_coord(GRID_X0), biased_coord(GRID_Y0));
        p.hblnk = (rand_bits(3) == 0);
        p.vblnk = (rand_bits(4) == 0);
        return p;
    endfunction

    function automatic game_state_t random_state();
        case (rand_bits(3))
            0, 1:    return STATE_PICK;
            2, 3:    return STATE_PLAY;
            4:       return STATE_GUESS;
            5:       return 6'b000001;
            6:       return 6'b001000;
            default: return game_state_t'(rand_bits(6));
        endcase
    endfunction

    // Card and in-card position for a screen point.
    function automatic logic locate(input int x, input int y, output int card,
                                    output int tx, output int ty);
        tx   = (x - GRID_X0) % TILE_SIZE;
        ty   = (y - GRID_Y0) % TILE_SIZE;
        card = ((y - GRID_Y0) / TILE_SIZE) * GRID_COLS + (x - GRID_X0) / TILE_SIZE;
        return (x >= GRID_X0) && (x < GRID_X0 + GRID_COLS * TILE_SIZE) &&
               (y >= GRID_Y0) && (y < GRID_Y0 + GRID_ROWS * TILE_SIZE);
    endfunction

    function automatic vga_sig_t predict(input vga_sig_t in, input game_state_t gs,
                                         output logic drawn, output logic framed);
        vga_sig_t   exp;
        int         card;
        int         tx;
        int         ty;
        card_idx_t  cidx;
        glyph_t     glyph;
        logic [5:0] bit_idx;
        exp    = in;
        drawn  = 1'b0;
        framed = 1'b0;
        if (locate(int'(in.hcount), int'(in.vcount), card, tx, ty) && !in.hblnk &&
            !in.vblnk && (gs == STATE_PICK || gs == STATE_PLAY || gs == STATE_GUESS)) begin
            drawn   = 1'b1;
            cidx    = card_idx_t'(card);
            framed  = your_valid_model && (card == your_card_model) &&
                      (tx < FRAME_WIDTH || tx >= TILE_SIZE - FRAME_WIDTH ||
                       ty < FRAME_WIDTH || ty >= TILE_SIZE - FRAME_WIDTH);
            glyph   = CARD_GLYPH[cidx];
            // Row 0 of the glyph is the top byte with its MSB on the left.
            bit_idx = 6'(63 - (ty / GLYPH_SCALE) * GLYPH_DIM - tx / GLYPH_SCALE);
            if (framed) begin
                exp.rgb = HIGHLIGHT_RGB;
            end else if (flip_model[cidx]) begin
                exp.rgb = BACK_RGB;
            end else if (glyph[bit_idx]) begin
                exp.rgb = CARD_RGB[cidx];
            end else begin
                exp.rgb = FACE_BG_RGB;
            end
        end
        return exp;
    endfunction

    task automatic compare_output(input vga_sig_t in);
        vga_sig_t exp;
        logic     drawn;
        logic     framed;
        exp = predict(in, game_state, drawn, framed);
        if (drawn) begin
            board_checks++;
            if (framed) begin
                frame_checks++;
            end
            check_rgb("vga_out.rgb", vga_out.rgb, exp.rgb);
        end
        check_vga("vga_out", vga_out, exp);
    endtask

    // One pixel per falling edge and outputs checked three pixels late.
    task automatic step(input vga_sig_t pix, input game_state_t gs, input logic left,
                        input logic right, input int cx, input int cy);
        int   card;
        int   tx;
        int   ty;
        logic hit;
        @(negedge clk);
        if (pipe.size() == 3) begin
            if (settle == 0) begin
                compare_output(pipe.pop_front());
            end else begin
                void'(pipe.pop_front());
            end
        end
        if (settle > 0) begin
            settle--;
        end
        hit = locate(cx, cy, card, tx, ty);
        if (left || right) begin
            settle = 5;
        end
        if (left && hit) begin
            flip_model[card_idx_t'(card)] = !flip_model[card_idx_t'(card)];
            flips_seen++;
        end
        if (right && hit) begin
            your_card_model  = card;
            your_valid_model = 1'b1;
            picks_seen++;
        end
        vga_in      = pix;
        game_state  = gs;
        mouse_left  = left;
        mouse_right = right;
        xpos        = mouse_pos_t'(cx);
        ypos        = mouse_pos_t'(cy);
        pipe.push_back(pix);
    endtask

    initial begin
        vga_sig_t idle;
        logic     left;
        logic     right;
        idle             = '0;
        rst              = 1'b1;
        vga_in           = '0;
        mouse_left       = 1'b0;
        mouse_right      = 1'b0;
        xpos             = '0;
        ypos             = '0;
        game_state       = '0;
        flip_model       = '0;
        your_card_model  = 0;
        your_valid_model = 1'b0;
        settle           = 0;
        flips_seen       = 0;
        picks_seen       = 0;
        board_checks     = 0;
        frame_checks     = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Every glyph cell of every card with all faces up.
        for (int c = 0; c < NUM_CARDS; c++) begin
            for (int gy = 0; gy < GLYPH_DIM; gy++) begin
                for (int gx = 0; gx < GLYPH_DIM; gx++) begin
                    step(board_pixel(GRID_X0 + (c % GRID_COLS) * TILE_SIZE + gx * GLYPH_SCALE + 3,
                                     GRID_Y0 + (c / GRID_COLS) * TILE_SIZE + gy * GLYPH_SCALE + 4),
                         STATE_PLAY, 1'b0, 1'b0, 0, 0);
                end
            end
        end

        for (int i = 0; i < RAND_CYCLES; i++) begin
            left  = 1'b0;
            right = 1'b0;
            if (settle == 0 && rand_bits(4) == 0) begin
                if (next_bit()) begin
                    left = 1'b1;
                end else begin
                    right = 1'b1;
                end
            end
            step(random_pixel(), random_state(), left, right,
                 biased_coord(GRID_X0), biased_coord(GRID_Y0));
        end

        // Pick the centre card, then sweep a row and a column across it.
        repeat (6) step(idle, STATE_GUESS, 1'b0, 1'b0, 0, 0);
        step(idle, STATE_GUESS, 1'b0, 1'b1, GRID_X0 + 96, GRID_Y0 + 96);
        repeat (4) step(idle, STATE_GUESS, 1'b0, 1'b0, 0, 0);
        for (int t = 0; t < TILE_SIZE; t++) begin
            step(board_pixel(GRID_X0 + TILE_SIZE + t, GRID_Y0 + TILE_SIZE + 20),
                 STATE_GUESS, 1'b0, 1'b0, 0, 0);
        end
        for (int t = 0; t < TILE_SIZE; t++) begin
            step(board_pixel(GRID_X0 + TILE_SIZE + 30, GRID_Y0 + TILE_SIZE + t),
                 STATE_GUESS, 1'b0, 1'b0, 0, 0);
        end
        repeat (3) step(idle, STATE_PICK, 1'b0, 1'b0, 0, 0);

        $display("Board pixels %0d, frame pixels %0d, flips %0d, picks %0d",
                 board_checks, frame_checks, flips_seen, picks_seen);
        if (flips_seen < 4 || picks_seen < 2) begin
            report_failure("Too few clicks were exercised");
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

// File: verilog/top_draw_board.sv
`timescale 1ns/1ps

module top_draw_board
    import vga_pkg::*;
    import board_pkg::*;
#(
    parameter int GRID_X0 = 64,
    parameter int GRID_Y0 = 48
) (
    input  logic        clk,
    input  logic        rst,
    input  vga_sig_t    vga_in,
    input  logic        mouse_left,
    input  logic        mouse_right,
    input  mouse_pos_t  xpos,
    input  mouse_pos_t  ypos,
    input  game_state_t game_state,
    output vga_sig_t    vga_out
);

    vga_sig_t  vga_d2;
    card_loc_t loc_d1;
    card_loc_t loc_d2;
    logic      flip_pulse;
    card_idx_t click_card;
    card_idx_t your_card;
    logic      your_valid;
    rgb_t      tile_rgb [NUM_CARDS];
    logic      tile_hit [NUM_CARDS];

    board_locator #(
        .GRID_X0(GRID_X0),
        .GRID_Y0(GRID_Y0)
    ) u_board_locator (
        .clk,
        .rst,
        .vga_in,
        .mouse_left,
        .mouse_right,
        .xpos,
        .ypos,
        .vga_d1(),
        .vga_d2,
        .loc_d1,
        .loc_d2,
        .flip_pulse,
        .pick_pulse(),
        .click_card,
        .your_card,
        .your_valid
    );

    // One tile per card.
    for (genvar i = 0; i < NUM_CARDS; i++) begin : g_card
        card_tile #(
            .CARD_ID(card_idx_t'(i))
        ) u_card_tile (
            .clk,
            .rst,
            .loc_d1,
            .flip_pulse,
            .click_card,
            .tile_rgb(tile_rgb[i]),
            .tile_hit(tile_hit[i])
        );
    end

    board_mixer u_board_mixer (
        .clk,
        .rst,
        .vga_d2,
        .loc_d2,
        .tile_rgb,
        .tile_hit,
        .your_card,
        .your_valid,
        .game_state,
        .vga_out
    );

endmodule

// File: verilog/board_mixer.sv
`timescale 1ns/1ps

module board_mixer
    import vga_pkg::*;
    import board_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  vga_sig_t    vga_d2,
    input  card_loc_t   loc_d2,
    input  rgb_t        tile_rgb [NUM_CARDS],
    input  logic        tile_hit [NUM_CARDS],
    input  card_idx_t   your_card,
    input  logic        your_valid,
    input  game_state_t game_state,
    output vga_sig_t    vga_out
);

    localparam tile_pos_t FRAME_LO = tile_pos_t'(FRAME_WIDTH);
    localparam tile_pos_t FRAME_HI = tile_pos_t'(TILE_SIZE - FRAME_WIDTH);

    rgb_t     board_rgb;
    logic     any_hit;
    logic     board_state;
    logic     on_frame;
    logic     draw_board;
    vga_sig_t vga_nxt;

    always_comb begin
        board_rgb = RGB_BLACK;
        any_hit   = 1'b0;
        for (int i = 0; i < NUM_CARDS; i++) begin
            if (tile_hit[i]) begin
                board_rgb = board_rgb | tile_rgb[i];
                any_hit   = 1'b1;
            end
        end
    end

    always_comb begin
        board_state = (game_state == STATE_PICK) || (game_state == STATE_PLAY) ||
                      (game_state == STATE_GUESS);
        // Highlight band along the edge of the player's card.
        on_frame = your_valid && loc_d2.hit && (loc_d2.card == your_card) &&
                   ((loc_d2.tile_x < FRAME_LO) || (loc_d2.tile_x >= FRAME_HI) ||
                    (loc_d2.tile_y < FRAME_LO) || (loc_d2.tile_y >= FRAME_HI));
        draw_board = board_state && any_hit && !vga_d2.hblnk && !vga_d2.vblnk;
    end

    always_comb begin
        vga_nxt = vga_d2;
        if (draw_board) begin
            vga_nxt.rgb = on_frame ? HIGHLIGHT_RGB : board_rgb;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vga_out <= '0;
        end else begin
            vga_out <= vga_nxt;
        end
    end

endmodule

// File: verilog/card_tile.sv
`timescale 1ns/1ps

module card_tile
    import vga_pkg::*;
    import board_pkg::*;
#(
    parameter card_idx_t CARD_ID = '0
) (
    input  logic      clk,
    input  logic      rst,
    input  card_loc_t loc_d1,
    input  logic      flip_pulse,
    input  card_idx_t click_card,
    output rgb_t      tile_rgb,
    output logic      tile_hit
);

    localparam glyph_t GLYPH = CARD_GLYPH[CARD_ID];

    logic       flipped;
    logic [2:0] glyph_x;
    logic [2:0] glyph_y;
    logic       glyph_bit;
    rgb_t       pix_rgb;

    always_ff @(posedge clk) begin
        if (rst) begin
            flipped <= 1'b0;
        end else if (flip_pulse && (click_card == CARD_ID)) begin
            flipped <= !flipped;
        end
    end

    always_comb begin
        glyph_x   = 3'(loc_d1.tile_x / GLYPH_SCALE);
        glyph_y   = 3'(loc_d1.tile_y / GLYPH_SCALE);
        // Row 0 sits in the top byte.
        glyph_bit = GLYPH[6'd63 - {glyph_y, glyph_x}];
        if (flipped) begin
            pix_rgb = BACK_RGB;
        end else if (glyph_bit) begin
            pix_rgb = CARD_RGB[CARD_ID];
        end else begin
            pix_rgb = FACE_BG_RGB;
        end
    end

    always_ff @(posedge clk) begin
        tile_rgb <= pix_rgb;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tile_hit <= 1'b0;
        end else begin
            tile_hit <= loc_d1.hit && (loc_d1.card == CARD_ID);
        end
    end

endmodule

// File: verilog/board_locator.sv
`timescale 1ns/1ps

module board_locator
    import vga_pkg::*;
    import board_pkg::*;
#(
    parameter int GRID_X0 = 0,
    parameter int GRID_Y0 = 0
) (
    input  logic       clk,
    input  logic       rst,
    input  vga_sig_t   vga_in,
    input  logic       mouse_left,
    input  logic       mouse_right,
    input  mouse_pos_t xpos,
    input  mouse_pos_t ypos,
    output vga_sig_t   vga_d1,
    output vga_sig_t   vga_d2,
    output card_loc_t  loc_d1,
    output card_loc_t  loc_d2,
    output logic       flip_pulse,
    output logic       pick_pulse,
    output card_idx_t  click_card,
    output card_idx_t  your_card,
    output logic       your_valid
);

    localparam mouse_pos_t X0      = mouse_pos_t'(GRID_X0);
    localparam mouse_pos_t Y0      = mouse_pos_t'(GRID_Y0);
    localparam mouse_pos_t BOARD_W = mouse_pos_t'(GRID_COLS * TILE_SIZE);
    localparam mouse_pos_t BOARD_H = mouse_pos_t'(GRID_ROWS * TILE_SIZE);

    card_loc_t pix_loc;
    card_loc_t cur_loc;
    logic      left_prev;
    logic      right_prev;
    logic      left_rise;
    logic      right_rise;

    // Same mapping for the pixel and the cursor.
    function automatic card_loc_t map_loc(input mouse_pos_t x, input mouse_pos_t y);
        mouse_pos_t rel_x;
        mouse_pos_t rel_y;
        card_idx_t  col;
        card_idx_t  row;
        card_loc_t  loc;
        rel_x      = x - X0;
        rel_y      = y - Y0;
        col        = card_idx_t'(rel_x / TILE_SIZE);
        row        = card_idx_t'(rel_y / TILE_SIZE);
        loc.hit    = (x >= X0) && (x < X0 + BOARD_W) && (y >= Y0) && (y < Y0 + BOARD_H);
        loc.card   = card_idx_t'(row * GRID_COLS) + col;
        loc.tile_x = tile_pos_t'(rel_x % TILE_SIZE);
        loc.tile_y = tile_pos_t'(rel_y % TILE_SIZE);
        return loc;
    endfunction

    always_comb begin
        pix_loc    = map_loc(mouse_pos_t'(vga_in.hcount), mouse_pos_t'(vga_in.vcount));
        cur_loc    = map_loc(xpos, ypos);
        left_rise  = mouse_left && !left_prev;
        right_rise = mouse_right && !right_prev;
    end

    // Two-stage delay of the stream and its location.
    always_ff @(posedge clk) begin
        if (rst) begin
            vga_d1 <= '0;
            vga_d2 <= '0;
            loc_d1 <= '0;
            loc_d2 <= '0;
        end else begin
            vga_d1 <= vga_in;
            vga_d2 <= vga_d1;
            loc_d1 <= pix_loc;
            loc_d2 <= loc_d1;
        end
    end

    // Click pulses carry the card under the cursor at the edge.
    always_ff @(posedge clk) begin
        if (rst) begin
            left_prev  <= 1'b0;
            right_prev <= 1'b0;
            flip_pulse <= 1'b0;
            pick_pulse <= 1'b0;
            click_card <= '0;
        end else begin
            left_prev  <= mouse_left;
            right_prev <= mouse_right;
            flip_pulse <= left_rise && cur_loc.hit;
            pick_pulse <= right_rise && cur_loc.hit;
            click_card <= cur_loc.card;
        end
    end

    // Player's own card.
    always_ff @(posedge clk) begin
        if (rst) begin
            your_card  <= '0;
            your_valid <= 1'b0;
        end else if (pick_pulse) begin
            your_card  <= click_card;
            your_valid <= 1'b1;
        end
    end

endmodule

// File: verilog/board_pkg.sv
package board_pkg;

    import vga_pkg::*;

    // Board geometry.
    localparam int NUM_CARDS   = 9;
    localparam int GRID_COLS   = 3;
    localparam int GRID_ROWS   = NUM_CARDS / GRID_COLS;
    localparam int TILE_SIZE   = 64;
    localparam int GLYPH_SCALE = 8;
    localparam int GLYPH_DIM   = TILE_SIZE / GLYPH_SCALE;
    localparam int FRAME_WIDTH = 2;

    typedef logic [3:0] card_idx_t;
    typedef logic [5:0] tile_pos_t;
    typedef logic [63:0] glyph_t;

    // Where a pixel or the cursor lies on the board.
    typedef struct packed {
        logic      hit;
        card_idx_t card;
        tile_pos_t tile_x;
        tile_pos_t tile_y;
    } card_loc_t;

    // One-hot game state from the game FSM.
    typedef logic [5:0] game_state_t;

    // States in which the board is drawn.
    localparam game_state_t STATE_PICK  = 6'b000010;
    localparam game_state_t STATE_PLAY  = 6'b010000;
    localparam game_state_t STATE_GUESS = 6'b100000;

    // Top row in the upper byte, leftmost pixel in the MSB of each row.
    localparam glyph_t CARD_GLYPH [NUM_CARDS] = '{
        64'h3C42_A581_A599_423C,
        64'h7E81_A581_BD81_423C,
        64'h3C7E_A581_99A5_423C,
        64'hFF81_A581_81BD_423C,
        64'h3C42_81A5_81BD_5A3C,
        64'h183C_66DB_FF7E_243C,
        64'h3C5A_A581_A599_663C,
        64'h7E42_A5A5_8199_427E,
        64'h3C42_A581_81FF_423C
    };

    localparam rgb_t CARD_RGB [NUM_CARDS] = '{
        12'hA00,
        12'h0A0,
        12'h00A,
        12'hA60,
        12'h60A,
        12'h0AA,
        12'h840,
        12'h444,
        12'hA06
    };

    localparam rgb_t FACE_BG_RGB   = 12'hFFF;
    localparam rgb_t BACK_RGB      = 12'h228;
    localparam rgb_t HIGHLIGHT_RGB = 12'hFF0;

endpackage

// File: verilog/vga_pkg.sv
package vga_pkg;

    // Screen coordinate as produced by the timing generator.
    typedef logic [10:0] coord_t;

    // 4 bits per channel, red in the top nibble.
    typedef logic [11:0] rgb_t;

    // Cursor coordinate from the mouse controller.
    typedef logic [11:0] mouse_pos_t;

    // One pixel of the VGA stream.
    typedef struct packed {
        coord_t hcount;
        coord_t vcount;
        logic   hsync;
        logic   vsync;
        logic   hblnk;
        logic   vblnk;
        rgb_t   rgb;
    } vga_sig_t;

    localparam rgb_t RGB_BLACK = 12'h000;

endpackage
